// File: vlog.f
src/som_pkg.sv
src/contador_m.sv
src/buzzer.sv
src/sequenciador_som.sv
src/gerador_som.sv
tb/tb_gerador_som.sv

// File: Bender.yml
package:
  name: gerador_som

dependencies: {}

sources:
  # package first, the modules import it
  - src/som_pkg.sv
  - src/contador_m.sv
  - src/buzzer.sv
  - src/sequenciador_som.sv
  - src/gerador_som.sv

  - target: test
    files:
      - tb/tb_gerador_som.sv

// File: tb/tb_gerador_som.sv
module tb_gerador_som
    import som_pkg::*;
();

    localparam int TICK_DIV   = 12;
    localparam int NUM_LINHAS = 7;
    // longest note is 7 ticks and a melody has at most 4 notes
    localparam int LIMITE     = NUM_LINHAS * 7 * 4 * TICK_DIV + 200;

    // one table row, the expected notes are what the first event must play
    typedef struct packed {
        evento_t               ev;
        logic                  injeta;    // second strobe in the middle of the melody
        evento_t               ev_extra;  // event carried by that second strobe
        logic [2:0]            n_notas;
        nota_t [MAX_NOTAS-1:0] notas;
    } linha_t;

    logic    clock;
    logic    rst;
    logic    evento_valido;
    evento_t evento;
    logic    pulso;
    logic    tocando;
    tone_t   nota;

    linha_t tabela [NUM_LINHAS];
    int     errors;
    int     cycles;

    gerador_som #(.TICK_DIV(TICK_DIV)) dut0 (
        .clock         (clock),
        .rst           (rst),
        .evento_valido (evento_valido),
        .evento        (evento),
        .pulso         (pulso),
        .tocando       (tocando),
        .nota          (nota)
    );

    // ========================================================================
    // clock and run limit
    // ========================================================================

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    initial begin
        cycles = 0;
        while (cycles < LIMITE) begin
            @(posedge clock);
            cycles++;
        end
        $display("timeout: the tests did not complete within %0d cycles", LIMITE);
        $display("errors: %0d", errors);
        $display("Finished with errors");
        $finish;
    end

    // ========================================================================
    // helpers
    // ========================================================================

    task automatic flag_mismatch(input string msg);
        errors++;
        $display("MISMATCH at time %0t: %s", $time, msg);
    endtask

    // pulses in a note that starts with all dividers at zero
    function automatic int pulses_expected(input int len, input tone_t t);
        case (t)
            OITAVO:  return len / 8;
            QUARTO:  return len / 4;
            TERCO:   return len / 3;
            MEIO:    return len / 2;
            default: return 0;
        endcase
    endfunction

    task automatic start_row(input int r, input evento_t ev, input logic inj,
                             input evento_t extra);
        tabela[r].ev       = ev;
        tabela[r].injeta   = inj;
        tabela[r].ev_extra = extra;
        tabela[r].n_notas  = 3'd0;
        tabela[r].notas    = '0;
    endtask

    task automatic add_note(input int r, input tone_t t, input int d);
        int k;
        k = tabela[r].n_notas;
        tabela[r].notas[k].tom = t;
        tabela[r].notas[k].dur = d[2:0];
        tabela[r].n_notas      = tabela[r].n_notas + 3'd1;
    endtask

    task automatic load_table();
        start_row(0, TECLA, 1'b0, TECLA);
        add_note(0, OITAVO, 2);
        start_row(1, ACERTO, 1'b0, TECLA);
        add_note(1, QUARTO, 2);
        add_note(1, MEIO, 2);
        start_row(2, ERRO, 1'b0, TECLA);
        add_note(2, TERCO, 4);
        start_row(3, VITORIA, 1'b0, TECLA);
        add_note(3, OITAVO, 1);
        add_note(3, QUARTO, 1);
        add_note(3, MEIO, 1);
        add_note(3, TERCO, 2);
        // the rows below carry a strobe that must be dropped
        start_row(4, VITORIA, 1'b1, ERRO);
        add_note(4, OITAVO, 1);
        add_note(4, QUARTO, 1);
        add_note(4, MEIO, 1);
        add_note(4, TERCO, 2);
        start_row(5, ACERTO, 1'b1, TECLA);
        add_note(5, QUARTO, 2);
        add_note(5, MEIO, 2);
        start_row(6, TECLA, 1'b1, VITORIA);
        add_note(6, OITAVO, 2);
    endtask

    // silent cycles, starts and ends on a rising edge
    task automatic check_idle(input int n);
        repeat (n) begin
            @(negedge clock);
            assert (tocando === 1'b0) else flag_mismatch("tocando high while idle");
            assert (nota === SILENCIO) else
                flag_mismatch($sformatf("nota is %b while idle", nota));
            assert (pulso === 1'b0) else flag_mismatch("pulso high while idle");
            @(posedge clock);
        end
    endtask

    // ========================================================================
    // one melody, cycle by cycle
    // ========================================================================

    task automatic play_row(input int r);
        linha_t row;
        tone_t  t;
        int     total;
        int     len;
        int     cyc;
        int     alto;
        int     pulsos;
        int     inject_at;
        int     k;
        int     c;

        row   = tabela[r];
        total = 0;
        for (k = 0; k < row.n_notas; k++) begin
            total += row.notas[k].dur * TICK_DIV;
        end
        inject_at = total / 2;

        evento_valido <= 1'b1;
        evento        <= row.ev;
        @(negedge clock);
        assert (tocando === 1'b0) else
            flag_mismatch($sformatf("row %0d: tocando high in the strobe cycle", r));
        @(posedge clock);
        evento_valido <= 1'b0;   // the DUT takes the event on this edge

        cyc  = 0;
        alto = 0;
        for (k = 0; k < row.n_notas; k++) begin
            t      = row.notas[k].tom;
            len    = row.notas[k].dur * TICK_DIV;
            pulsos = 0;
            for (c = 0; c < len; c++) begin
                @(negedge clock);
                if (tocando === 1'b1) alto++;
                if (pulso === 1'b1) pulsos++;
                assert (nota === t) else
                    flag_mismatch($sformatf("row %0d note %0d cycle %0d: nota %b, expected %b",
                                            r, k, c, nota, t));
                @(posedge clock);
                if (row.injeta && cyc == inject_at) begin
                    evento_valido <= 1'b1;   // should be ignored
                    evento        <= row.ev_extra;
                end else begin
                    evento_valido <= 1'b0;
                end
                cyc++;
            end
            assert (pulsos == pulses_expected(len, t)) else
                flag_mismatch($sformatf("row %0d note %0d: %0d pulses, expected %0d",
                                        r, k, pulsos, pulses_expected(len, t)));
        end

        assert (alto == total) else
            flag_mismatch($sformatf("row %0d: tocando high %0d cycles, expected %0d",
                                    r, alto, total));
        @(negedge clock);
        assert (tocando === 1'b0) else
            flag_mismatch($sformatf("row %0d: tocando still high after %0d cycles", r, total));
        assert (nota === SILENCIO) else
            flag_mismatch($sformatf("row %0d: nota %b after the melody", r, nota));

        // a melody that runs long is left to finish before the next row
        while (tocando !== 1'b0) @(negedge clock);
        @(posedge clock);
    endtask

    // ========================================================================
    // main sequence
    // ========================================================================

    initial begin
        int r;
        int gap;

        errors        = 0;
        rst           = 1'b1;
        evento_valido = 1'b0;
        evento        = TECLA;
        void'($urandom(60));
        load_table();

        repeat (8) @(posedge clock);
        rst <= 1'b0;

        check_idle(10);   // nothing may sound before the first event

        for (r = 0; r < NUM_LINHAS; r++) begin
            gap = 1 + ($urandom % 5);
            check_idle(gap);
            play_row(r);
        end

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: src/gerador_som.sv
module gerador_som
    import som_pkg::*;
#(
    parameter int TICK_DIV = 12      // clock cycles per melody tick
) (
    input  logic    clock,
    input  logic    rst,
    input  logic    evento_valido,   // one-cycle event strobe
    input  evento_t evento,
    output logic    pulso,           // buzzer drive
    output logic    tocando,         // a melody is playing
    output tone_t   nota             // tone sounding right now
);

    // ========================================================================
    // internal connections
    // ========================================================================

    tone_t seletor;
    logic  conta;
    logic  reinicia;

    // event to melody, one note after another
    sequenciador_som #(.TICK_DIV(TICK_DIV)) seq0 (
        .clock         (clock),
        .rst           (rst),
        .evento_valido (evento_valido),
        .evento        (evento),
        .seletor       (seletor),
        .conta         (conta),
        .reinicia      (reinicia),
        .tocando       (tocando)
    );

    // tone generation for the selected note
    buzzer buz0 (
        .clock    (clock),
        .rst      (rst),
        .reinicia (reinicia),
        .conta    (conta),
        .seletor  (seletor),
        .pulso    (pulso)
    );

    assign nota = seletor;  // lets the game side follow the melody

endmodule

// File: src/sequenciador_som.sv
module sequenciador_som
    import som_pkg::*;
#(
    parameter int TICK_DIV = 12      // clock cycles per tick, 2 or more
) (
    input  logic    clock,
    input  logic    rst,
    input  logic    evento_valido,   // one-cycle strobe, ignored while playing
    input  evento_t evento,
    output tone_t   seletor,         // tone for the buzzer, silence when idle
    output logic    conta,           // enables the buzzer dividers
    output logic    reinicia,        // restarts the dividers for the next note
    output logic    tocando          // high for the whole melody
);

    localparam int TICK_W = $clog2(TICK_DIV);
    localparam int IDX_W  = $clog2(MAX_NOTAS);

    typedef enum logic {
        OCIOSO,
        TOCANDO
    } estado_t;

    // ========================================================================
    // declarations
    // ========================================================================

    estado_t          estado;
    evento_t          evento_r;      // event whose melody is playing
    logic [IDX_W-1:0] indice;        // position of the current note
    logic [2:0]       ticks_rest;    // ticks left in the current note

    logic [IDX_W-1:0] indice_prox;
    nota_t            nota_atual;
    nota_t            nota_prox;
    logic             tick;          // last cycle of a tick
    logic             inicia;        // accepted strobe
    logic             fim_nota;      // last cycle of the current note
    logic             ultima_nota;   // current note closes the melody

    // ========================================================================
    // tick prescaler
    // ========================================================================

    // it only runs while playing, and a restart puts it back in step with
    // the note, so a note of dur ticks lasts dur * TICK_DIV cycles
    contador_m #(.M(TICK_DIV), .N(TICK_W)) cont_tick (
        .clock  (clock),
        .rst    (rst),
        .zera_s (reinicia),
        .conta  (tocando),
        .q      (),
        .fim    (tick),
        .meio   ()
    );

    // ========================================================================
    // note lookup
    // ========================================================================

    always_comb begin
        indice_prox = indice + 1'b1;
        nota_atual  = MELODIA[evento_r][indice];
        nota_prox   = MELODIA[evento_r][indice_prox];
        // the count is 3 bits wide so a full four-note melody fits
        ultima_nota = ({1'b0, indice} + 3'd1) >= NUM_NOTAS[evento_r];
    end

    assign inicia   = (estado == OCIOSO) && evento_valido;
    assign fim_nota = (estado == TOCANDO) && tick && (ticks_rest == 3'd1);

    // ========================================================================
    // playback FSM
    // ========================================================================

    always_ff @(posedge clock) begin
        if (rst) begin
            estado     <= OCIOSO;
            evento_r   <= TECLA;
            indice     <= '0;
            ticks_rest <= '0;
        end else begin
            case (estado)
                OCIOSO: begin
                    if (evento_valido) begin
                        estado     <= TOCANDO;
                        evento_r   <= evento;
                        indice     <= '0;
                        ticks_rest <= MELODIA[evento][0].dur;
                    end
                end

                TOCANDO: begin
                    if (tick) begin
                        if (ticks_rest != 3'd1) begin
                            ticks_rest <= ticks_rest - 3'd1;
                        end else if (!ultima_nota) begin
                            // next note follows without a gap
                            indice     <= indice_prox;
                            ticks_rest <= nota_prox.dur;
                        end else begin
                            estado <= OCIOSO;  // melody done
                        end
                    end
                end

                default: begin
                    estado <= OCIOSO;
                end
            endcase
        end
    end

    // ========================================================================
    // outputs
    // ========================================================================

    assign tocando = (estado == TOCANDO);
    assign conta   = tocando;

    // evento_r and indice keep their last values after a melody ends,
    // so the tone is forced to silence outside playback
    assign seletor = tocando ? nota_atual.tom : SILENCIO;

    // the restart is raised in the cycle whose closing edge starts a note.
    // Counters are then at zero in the note's first cycle and the first
    // divider pulse lands in its M-th cycle
    assign reinicia = inicia | (fim_nota & ~ultima_nota);

endmodule

// File: src/buzzer.sv
module buzzer
    import som_pkg::*;
(
    input  logic  clock,
    input  logic  rst,
    input  logic  reinicia,   // one-cycle pulse that restarts every divider
    input  logic  conta,      // dividers only advance while a melody plays
    input  tone_t seletor,
    output logic  pulso       // one-cycle high at the selected tone's rate
);

    logic limpa;              // clear for all four dividers
    logic pulso_meio;
    logic pulso_quarto;
    logic pulso_oitavo;
    logic pulso_terco;

    assign limpa = rst | reinicia;

    // ========================================================================
    // clock dividers
    // ========================================================================

    // clock/2
    contador_m #(.M(2), .N(1)) cont_2 (
        .clock  (clock),
        .rst    (rst),
        .zera_s (limpa),
        .conta  (conta),
        .q      (),
        .fim    (pulso_meio),
        .meio   ()
    );

    // clock/4
    contador_m #(.M(4), .N(2)) cont_4 (
        .clock  (clock),
        .rst    (rst),
        .zera_s (limpa),
        .conta  (conta),
        .q      (),
        .fim    (pulso_quarto),
        .meio   ()
    );

    // clock/8
    contador_m #(.M(8), .N(3)) cont_8 (
        .clock  (clock),
        .rst    (rst),
        .zera_s (limpa),
        .conta  (conta),
        .q      (),
        .fim    (pulso_oitavo),
        .meio   ()
    );

    // clock/3, gated by conta like the others so every note starts in phase
    contador_m #(.M(3), .N(2)) cont_3 (
        .clock  (clock),
        .rst    (rst),
        .zera_s (limpa),
        .conta  (conta),
        .q      (),
        .fim    (pulso_terco),
        .meio   ()
    );

    // ========================================================================
    // tone selector
    // ========================================================================

    // anything that is not exactly one-hot stays silent
    always_comb begin
        case (seletor)
            OITAVO:  pulso = pulso_oitavo;
            QUARTO:  pulso = pulso_quarto;
            TERCO:   pulso = pulso_terco;
            MEIO:    pulso = pulso_meio;
            default: pulso = 1'b0;
        endcase
    end

endmodule

// File: src/contador_m.sv
module contador_m #(
    parameter int M = 8,             // modulus
    parameter int N = 3              // width of q
) (
    input  logic         clock,
    input  logic         rst,
    input  logic         zera_s,     // synchronous clear, wins over conta
    input  logic         conta,      // count enable
    output logic [N-1:0] q,
    output logic         fim,        // q is at its last state
    output logic         meio        // q is at the half-way state
);

    localparam logic [N-1:0] ULTIMO   = N'(M - 1);
    localparam logic [N-1:0] METADE_Q = N'(M / 2 - 1);

    // ========================================================================
    // count register
    // ========================================================================

    always_ff @(posedge clock) begin
        if (rst || zera_s) begin
            q <= '0;
        end else if (conta) begin
            if (q == ULTIMO) begin
                q <= '0;             // wrap back to zero
            end else begin
                q <= q + 1'b1;
            end
        end
    end

    // flags follow q directly, so fim is high for one whole state
    always_comb begin
        fim  = (q == ULTIMO);
        meio = (q == METADE_Q);
    end

endmodule

// File: src/som_pkg.sv
package som_pkg;

    // ========================================================================
    // tone and event encodings
    // ========================================================================

    // one-hot selector for the buzzer dividers, all zeros is silence
    typedef enum logic [3:0] {
        SILENCIO = 4'b0000,
        OITAVO   = 4'b0001,  // clock/8
        QUARTO   = 4'b0010,  // clock/4
        TERCO    = 4'b0100,  // clock/3
        MEIO     = 4'b1000   // clock/2
    } tone_t;

    // game events that have a melody of their own
    typedef enum logic [1:0] {
        TECLA   = 2'd0,
        ACERTO  = 2'd1,
        ERRO    = 2'd2,
        VITORIA = 2'd3
    } evento_t;

    // one note of a melody, dur counts ticks and is never 0 in a used slot
    typedef struct packed {
        tone_t      tom;
        logic [2:0] dur;
    } nota_t;

    localparam int MAX_NOTAS = 4;  // longest melody in the table

    // ========================================================================
    // melody table
    // ========================================================================

    localparam nota_t NOTA_NULA = '{tom: SILENCIO, dur: 3'd0};  // filler for unused slots

    // rows follow the evento_t order
    localparam nota_t MELODIA [4][MAX_NOTAS] = '{
        '{'{tom: OITAVO, dur: 3'd2}, NOTA_NULA, NOTA_NULA, NOTA_NULA},
        '{'{tom: QUARTO, dur: 3'd2}, '{tom: MEIO, dur: 3'd2}, NOTA_NULA, NOTA_NULA},
        '{'{tom: TERCO, dur: 3'd4}, NOTA_NULA, NOTA_NULA, NOTA_NULA},
        '{'{tom: OITAVO, dur: 3'd1}, '{tom: QUARTO, dur: 3'd1},
          '{tom: MEIO, dur: 3'd1}, '{tom: TERCO, dur: 3'd2}}
    };

    // number of notes actually played for each event
    localparam logic [2:0] NUM_NOTAS [4] = '{3'd1, 3'd2, 3'd1, 3'd4};

endpackage
